// File: verilog/neuro_pkg.sv
`default_nettype none

package neuro_pkg;

    // ============================
    // Fixed-point format
    // ============================

    // Q3.14 samples throughout the loop
    localparam int WIDTH = 18;
    localparam int FRAC = 14;

    typedef logic signed [WIDTH-1:0] sample_t;

    // 1/3 for the L6 average
    localparam sample_t ONE_THIRD = 18'sd5461;

    // 0.25 phase coupling gain
    localparam sample_t K_PHASE_DEFAULT = 18'sd4096;

    // Coupled oscillators, one per pattern bit
    localparam int N_UNITS = 6;

    // ============================
    // Stage payloads
    // ============================

    // Oscillator states read once per sample strobe
    typedef struct packed {
        // Index order sets the pattern bit
        // 0 sensory L2/3, 1 sensory L6, 2 association L2/3
        // 3 association L6, 4 motor L2/3, 5 motor L6
        sample_t [N_UNITS-1:0] layer;
        sample_t               motor_l5a;
        sample_t               motor_l5b;
        sample_t               theta_x;
        sample_t               theta_y;
    } cortex_state_t;

    // Stage 1 result
    typedef struct packed {
        logic [N_UNITS-1:0] pattern;
        sample_t            alpha_feedback;
        sample_t            beta_amplitude;
        logic               beta_quiet;
        logic [2:0]         theta_phase;
        sample_t            theta_x;
    } feature_t;

    // Stage 2 result
    typedef struct packed {
        logic [N_UNITS-1:0] phase_pattern;
        logic               learning;
        logic               recalling;
        logic [2:0]         theta_phase;
        sample_t            theta_x;
        sample_t            alpha_feedback;
        logic               beta_quiet;
    } memory_t;

    // Stage 3 result, couplings plus forwarded CA3 status
    typedef struct packed {
        sample_t [N_UNITS-1:0] couple;
        memory_t               status;
    } coupling_t;

endpackage

`default_nettype wire

// File: verilog/sample_clock_enable.sv
`timescale 1ns/1ps
`default_nettype none

module sample_clock_enable #(
    parameter int SAMPLE_DIV = 31250
) (
    input  wire  clk,
    input  wire  reset,
    output logic sample_en
);

    // Counter wide enough for SAMPLE_DIV-1, at least one bit
    localparam int CW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [CW-1:0] RELOAD = CW'(SAMPLE_DIV - 1);

    logic [CW-1:0] count;

    // Down-counter, strobe on the zero crossing
    // With SAMPLE_DIV of 1 the count sits at zero and the strobe stays high
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= RELOAD;
            sample_en <= 1'b0;
        end else if (count == '0) begin
            count     <= RELOAD;
            sample_en <= 1'b1;
        end else begin
            count     <= count - 1'b1;
            sample_en <= 1'b0;
        end
    end

    // Divider of zero has no meaning
    a_div_range: assert property (@(posedge clk) SAMPLE_DIV >= 1);

    // Strobe is a single-cycle pulse whenever the divider is active
    a_strobe_single: assert property (@(posedge clk) disable iff (reset)
        (SAMPLE_DIV > 1 && sample_en) |=> !sample_en);

endmodule

`default_nettype wire

// File: verilog/cortical_feature_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cortical_feature_stage #(
    parameter neuro_pkg::sample_t BETA_QUIET_THRESH = 18'sd2458
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           sample_en,
    input  wire neuro_pkg::cortex_state_t cortex,
    output neuro_pkg::feature_t           feature,
    output logic                          feature_valid
);

    localparam int W = neuro_pkg::WIDTH;

    logic [neuro_pkg::N_UNITS-1:0] pattern;
    logic signed [W+1:0]           l6_sum;
    logic signed [2*W+1:0]         l6_avg_full;
    neuro_pkg::sample_t            alpha_feedback;
    logic signed [W:0]             l5a_abs;
    logic signed [W:0]             l5b_abs;
    logic signed [W:0]             beta_sum;
    neuro_pkg::sample_t            beta_amplitude;
    logic [W-1:0]                  theta_x_mag;
    logic [W-1:0]                  theta_y_mag;
    logic [2:0]                    theta_phase;

    // ============================
    // Cortical pattern
    // ============================

    // Layer active when its output is not negative
    always_comb begin
        for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
            pattern[i] = ~cortex.layer[i][W-1];
        end
    end

    // ============================
    // Alpha and beta
    // ============================

    // Sum of the three L6 outputs, two guard bits
    assign l6_sum = cortex.layer[1] + cortex.layer[3] + cortex.layer[5];
    // Scale by 1/3 for the average
    assign l6_avg_full = l6_sum * neuro_pkg::ONE_THIRD;
    assign alpha_feedback = neuro_pkg::sample_t'(l6_avg_full >>> neuro_pkg::FRAC);

    // Motor L5 magnitudes with one extra bit so -min stays positive
    assign l5a_abs = cortex.motor_l5a[W-1] ? -cortex.motor_l5a : cortex.motor_l5a;
    assign l5b_abs = cortex.motor_l5b[W-1] ? -cortex.motor_l5b : cortex.motor_l5b;
    assign beta_sum = l5a_abs + l5b_abs;
    // Mean of low and high beta
    assign beta_amplitude = neuro_pkg::sample_t'(beta_sum >>> 1);

    // ============================
    // Theta octant
    // ============================

    // Unsigned magnitudes for the diagonal test
    assign theta_x_mag = cortex.theta_x[W-1] ? -cortex.theta_x : cortex.theta_x;
    assign theta_y_mag = cortex.theta_y[W-1] ? -cortex.theta_y : cortex.theta_y;

    // Bit 2 is the half cycle, bit 1 the y sign, bit 0 steep versus shallow
    assign theta_phase = {cortex.theta_x[W-1], cortex.theta_y[W-1], theta_y_mag > theta_x_mag};

    // Capture on the strobe edge
    always_ff @(posedge clk) begin
        if (reset) begin
            feature_valid <= 1'b0;
        end else begin
            feature_valid <= sample_en;
            if (sample_en) begin
                feature.pattern        <= pattern;
                feature.alpha_feedback <= alpha_feedback;
                feature.beta_amplitude <= beta_amplitude;
                // Quiet beta opens the resonance window
                feature.beta_quiet     <= beta_amplitude < BETA_QUIET_THRESH;
                feature.theta_phase    <= theta_phase;
                feature.theta_x        <= cortex.theta_x;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ca3_phase_memory.sv
`timescale 1ns/1ps
`default_nettype none

module ca3_phase_memory (
    input  wire                      clk,
    input  wire                      reset,
    input  wire neuro_pkg::feature_t feature,
    input  wire                      feature_valid,
    output neuro_pkg::memory_t       memory,
    output logic                     memory_valid
);

    localparam int N_SLOTS = 8;

    // One pattern slot per theta octant
    logic [neuro_pkg::N_UNITS-1:0] slot [N_SLOTS];
    logic                          encoding;
    logic [2:0]                    slot_addr;
    logic [neuro_pkg::N_UNITS-1:0] recalled;

    // Phases 0 to 3 encode and phases 4 to 7 retrieve
    assign encoding = ~feature.theta_phase[2];

    // Window bit cleared so retrieval octant k+4 reads what octant k wrote
    assign slot_addr = feature.theta_phase & 3'b011;
    assign recalled  = slot[slot_addr];

    // ============================
    // Learn or recall per sample
    // ============================

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < N_SLOTS; s++) begin
                slot[s] <= '0;
            end
            memory_valid     <= 1'b0;
            memory.learning  <= 1'b0;
            memory.recalling <= 1'b0;
        end else begin
            memory_valid <= feature_valid;
            if (feature_valid) begin
                // Encoding half stores the cortical pattern and echoes it
                if (encoding) begin
                    slot[slot_addr]      <= feature.pattern;
                    memory.phase_pattern <= feature.pattern;
                end else begin
                    // Retrieval half plays back the stored pattern
                    memory.phase_pattern <= recalled;
                end
                memory.learning       <= encoding;
                memory.recalling      <= ~encoding;
                // Side fields ride along for the coupling stage and the ports
                memory.theta_phase    <= feature.theta_phase;
                memory.theta_x        <= feature.theta_x;
                memory.alpha_feedback <= feature.alpha_feedback;
                memory.beta_quiet     <= feature.beta_quiet;
            end
        end
    end

    // Learning and recall never overlap, across every sample held on the output
    a_learn_recall_excl: assert property (@(posedge clk) disable iff (reset)
        !(memory.learning && memory.recalling));

endmodule

`default_nettype wire

// File: verilog/phase_coupling_stage.sv
`timescale 1ns/1ps
`default_nettype none

module phase_coupling_stage #(
    parameter neuro_pkg::sample_t K_PHASE = neuro_pkg::K_PHASE_DEFAULT
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire neuro_pkg::memory_t memory,
    input  wire                     memory_valid,
    output neuro_pkg::coupling_t    coupling,
    output logic                    out_valid
);

    localparam int W = neuro_pkg::WIDTH;

    logic signed [2*W-1:0] theta_scaled;
    neuro_pkg::sample_t    couple_base;

    // ============================
    // Theta coupling drive
    // ============================

    // Full-precision product then back to Q3.14
    assign theta_scaled = K_PHASE * memory.theta_x;
    assign couple_base  = neuro_pkg::sample_t'(theta_scaled >>> neuro_pkg::FRAC);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid                 <= 1'b0;
            coupling.status.learning  <= 1'b0;
            coupling.status.recalling <= 1'b0;
        end else begin
            out_valid <= memory_valid;
            if (memory_valid) begin
                // Set bit pulls in phase, clear bit pushes anti-phase
                for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
                    coupling.couple[i] <= memory.phase_pattern[i] ? couple_base
                                                                  : -couple_base;
                end
                // Status passes through untouched
                coupling.status <= memory;
            end
        end
    end

    // Output stays quiet while the pipeline is held in reset
    a_no_valid_in_reset: assert property (@(posedge clk) reset |=> !out_valid);

endmodule

`default_nettype wire

// File: verilog/neural_loop_top.sv
`timescale 1ns/1ps
`default_nettype none

module neural_loop_top #(
    // Clock cycles per sample
    parameter int                 SAMPLE_DIV        = 31250,
    // About 0.15 in Q3.14
    parameter neuro_pkg::sample_t BETA_QUIET_THRESH = 18'sd2458,
    parameter neuro_pkg::sample_t K_PHASE           = neuro_pkg::K_PHASE_DEFAULT
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire neuro_pkg::cortex_state_t cortex,
    output neuro_pkg::coupling_t          coupling,
    output logic                          out_valid
);

    logic                sample_en;
    neuro_pkg::feature_t feature;
    logic                feature_valid;
    neuro_pkg::memory_t  memory;
    logic                memory_valid;

    // ============================
    // Cortex to CA3 and back
    // ============================

    // Sample strobe
    sample_clock_enable #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) u_sample_en (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en)
    );

    // Stage 1 pattern, alpha, beta and theta octant
    cortical_feature_stage #(
        .BETA_QUIET_THRESH(BETA_QUIET_THRESH)
    ) u_features (
        .clk           (clk),
        .reset         (reset),
        .sample_en     (sample_en),
        .cortex        (cortex),
        .feature       (feature),
        .feature_valid (feature_valid)
    );

    // Stage 2 theta-gated pattern store
    ca3_phase_memory u_ca3 (
        .clk           (clk),
        .reset         (reset),
        .feature       (feature),
        .feature_valid (feature_valid),
        .memory        (memory),
        .memory_valid  (memory_valid)
    );

    // Stage 3 signed coupling back to the columns
    phase_coupling_stage #(
        .K_PHASE(K_PHASE)
    ) u_coupling (
        .clk          (clk),
        .reset        (reset),
        .memory       (memory),
        .memory_valid (memory_valid),
        .coupling     (coupling),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

// File: test/neural_loop_model.svh
`ifndef NEURAL_LOOP_MODEL_SVH
`define NEURAL_LOOP_MODEL_SVH
`default_nettype none

// ============================
// Expected outputs
// ============================

// Predicted outputs in sample order, each with the edge it is due on
neuro_pkg::coupling_t expected_q [$];
int unsigned          due_q [$];

// Model copy of the eight CA3 slots
logic [neuro_pkg::N_UNITS-1:0] model_slot [8];

task automatic clear_model();
    for (int s = 0; s < 8; s++) begin
        model_slot[s] = '0;
    end
    expected_q.delete();
    due_q.delete();
endtask

// Sign-extend a sample for integer math
function automatic longint to_int(neuro_pkg::sample_t v);
    return v;
endfunction

function automatic longint magnitude(neuro_pkg::sample_t v);
    return (to_int(v) < 0) ? -to_int(v) : to_int(v);
endfunction

// ============================
// One sample, all three stages
// ============================

function automatic neuro_pkg::coupling_t predict_output(neuro_pkg::cortex_state_t c);
    neuro_pkg::coupling_t          r;
    logic [neuro_pkg::N_UNITS-1:0] pat;
    logic [2:0]                    phase;
    longint                        l6_sum;
    longint                        beta;
    neuro_pkg::sample_t            scaled;
    r = '0;
    // Layer counts as active when not negative
    for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
        pat[i] = to_int(c.layer[i]) >= 0;
    end
    // L6 mean through the one-third constant
    l6_sum = to_int(c.layer[1]) + to_int(c.layer[3]) + to_int(c.layer[5]);
    r.status.alpha_feedback = neuro_pkg::sample_t'(
        (l6_sum * to_int(neuro_pkg::ONE_THIRD)) >>> neuro_pkg::FRAC);
    // Half the summed L5 magnitudes
    beta = (magnitude(c.motor_l5a) + magnitude(c.motor_l5b)) >>> 1;
    r.status.beta_quiet = beta < to_int(BETA_QUIET_THRESH);
    // Octant from the two signs and the steepness
    phase[2] = to_int(c.theta_x) < 0;
    phase[1] = to_int(c.theta_y) < 0;
    phase[0] = magnitude(c.theta_y) > magnitude(c.theta_x);
    // Encoding half stores, retrieval half reads the matching slot
    if (!phase[2]) begin
        model_slot[{1'b0, phase[1:0]}] = pat;
        r.status.phase_pattern = pat;
        r.status.learning = 1'b1;
    end else begin
        r.status.phase_pattern = model_slot[{1'b0, phase[1:0]}];
        r.status.recalling = 1'b1;
    end
    r.status.theta_phase = phase;
    r.status.theta_x = c.theta_x;
    // Gain applied once, sign per recalled bit
    scaled = neuro_pkg::sample_t'((to_int(K_PHASE) * to_int(c.theta_x)) >>> neuro_pkg::FRAC);
    for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
        r.couple[i] = r.status.phase_pattern[i] ? scaled : -scaled;
    end
    return r;
endfunction

`default_nettype wire
`endif

// File: test/neural_loop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module neural_loop_tb;

    localparam int                 SAMPLE_DIV        = 2;
    localparam neuro_pkg::sample_t BETA_QUIET_THRESH = 18'sd2458;
    localparam neuro_pkg::sample_t K_PHASE           = neuro_pkg::K_PHASE_DEFAULT;
    localparam int                 N_RANDOM          = 2000;
    localparam int                 DRAIN_LIMIT       = 20;

    logic                     clk;
    logic                     reset;
    neuro_pkg::cortex_state_t cortex;
    neuro_pkg::coupling_t     coupling;
    logic                     out_valid;

    integer      seed;
    int unsigned edge_count;
    int unsigned applied;
    int unsigned checked;
    logic        running;
    logic        seen_output;

    `include "neural_loop_model.svh"

    neural_loop_top #(
        .SAMPLE_DIV        (SAMPLE_DIV),
        .BETA_QUIET_THRESH (BETA_QUIET_THRESH),
        .K_PHASE           (K_PHASE)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .cortex    (cortex),
        .coupling  (coupling),
        .out_valid (out_valid)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // ============================
    // Reporting
    // ============================

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            stop_with($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // ============================
    // Stimulus
    // ============================

    // Uniform in plus or minus 2^16
    function automatic neuro_pkg::sample_t rand_sample();
        return neuro_pkg::sample_t'($random(seed) % 65537);
    endfunction

    function automatic neuro_pkg::cortex_state_t random_state();
        neuro_pkg::cortex_state_t s;
        for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
            s.layer[i] = rand_sample();
        end
        s.motor_l5a = rand_sample();
        s.motor_l5b = rand_sample();
        s.theta_x   = rand_sample();
        s.theta_y   = rand_sample();
        return s;
    endfunction

    function automatic neuro_pkg::cortex_state_t with_theta(neuro_pkg::cortex_state_t s,
                                                             int x, int y);
        s.theta_x = neuro_pkg::sample_t'(x);
        s.theta_y = neuro_pkg::sample_t'(y);
        return s;
    endfunction

    function automatic neuro_pkg::cortex_state_t with_beta(neuro_pkg::cortex_state_t s,
                                                            int a, int b);
        s.motor_l5a = neuro_pkg::sample_t'(a);
        s.motor_l5b = neuro_pkg::sample_t'(b);
        return s;
    endfunction

    // Strobe rises every SAMPLE_DIV edges from edge SAMPLE_DIV, data taken one edge later
    function automatic logic is_sample_edge(int unsigned k);
        return k > SAMPLE_DIV && ((k - 1) % SAMPLE_DIV) == 0;
    endfunction

    // One clock edge, recording a prediction when the DUT samples
    task automatic step_edge(output logic taken);
        @(posedge clk);
        edge_count++;
        taken = is_sample_edge(edge_count);
        if (taken) begin
            expected_q.push_back(predict_output(cortex));
            // Registered through stages 1 to 3, visible two edges on
            due_q.push_back(edge_count + 2);
            applied++;
        end
        #2;
    endtask

    // Hold one sample until the strobe takes it
    task automatic apply_sample(input neuro_pkg::cortex_state_t s);
        logic taken;
        int   tries;
        taken  = 1'b0;
        tries  = 0;
        cortex = s;
        while (!taken) begin
            if (tries > SAMPLE_DIV + 1) begin
                stop_with("sample strobe did not arrive within the expected window");
            end
            step_edge(taken);
            tries++;
        end
    endtask

    // ============================
    // Output checker
    // ============================

    always @(negedge clk) begin : check_outputs
        neuro_pkg::coupling_t exp_out;
        if (running) begin
            if (due_q.size() != 0 && due_q[0] == edge_count) begin
                exp_out = expected_q.pop_front();
                void'(due_q.pop_front());
                check_value("out_valid", out_valid, 1'b1);
                for (int i = 0; i < neuro_pkg::N_UNITS; i++) begin
                    check_value($sformatf("couple[%0d]", i), coupling.couple[i],
                                exp_out.couple[i]);
                end
                check_value("phase_pattern", coupling.status.phase_pattern,
                            exp_out.status.phase_pattern);
                check_value("learning", coupling.status.learning, exp_out.status.learning);
                check_value("recalling", coupling.status.recalling, exp_out.status.recalling);
                check_value("theta_phase", coupling.status.theta_phase,
                            exp_out.status.theta_phase);
                check_value("theta_x", coupling.status.theta_x, exp_out.status.theta_x);
                check_value("alpha_feedback", coupling.status.alpha_feedback,
                            exp_out.status.alpha_feedback);
                check_value("beta_quiet", coupling.status.beta_quiet,
                            exp_out.status.beta_quiet);
                checked++;
                seen_output = 1'b1;
            end else begin
                // No pulse between samples
                check_value("out_valid", out_valid, 1'b0);
                if (!seen_output) begin
                    check_value("learning", coupling.status.learning, 1'b0);
                    check_value("recalling", coupling.status.recalling, 1'b0);
                end
            end
        end
    end

    // ============================
    // Test sequence
    // ============================

    initial begin : main
        logic        taken;
        int unsigned target;
        int          wait_cycles;
        clk         = 1'b0;
        reset       = 1'b1;
        cortex      = '0;
        seed        = 31735;
        edge_count  = 0;
        applied     = 0;
        checked     = 0;
        running     = 1'b0;
        seen_output = 1'b0;
        clear_model();
        repeat (4) @(posedge clk);
        #2;
        reset   = 1'b0;
        running = 1'b1;

        // Retrieval octants 4 to 7 before any write, slots read zero
        apply_sample(with_theta(random_state(), -1000, 100));
        apply_sample(with_theta(random_state(), -100, 1000));
        apply_sample(with_theta(random_state(), -1000, -100));
        apply_sample(with_theta(random_state(), -100, -1000));

        // All zero, pattern all ones and octant 0
        apply_sample('0);

        // Beta amplitude on and around the quiet threshold
        apply_sample(with_beta(random_state(), 2458, 2458));
        apply_sample(with_beta(random_state(), 2457, 2457));
        apply_sample(with_beta(random_state(), -2458, 2458));
        apply_sample(with_beta(random_state(), 2459, 2458));
        apply_sample(with_beta(random_state(), 2458, -2457));
        apply_sample(with_beta(random_state(), 0, 0));

        // Theta on the axes and diagonals
        apply_sample(with_theta(random_state(), 1000, 0));
        apply_sample(with_theta(random_state(), 0, 1000));
        apply_sample(with_theta(random_state(), 0, -1000));
        apply_sample(with_theta(random_state(), 1000, -1000));
        apply_sample(with_theta(random_state(), -1000, 0));
        apply_sample(with_theta(random_state(), -1000, 1000));
        apply_sample(with_theta(random_state(), -1000, -1000));
        apply_sample(with_theta(random_state(), 1000, 1000));

        // Random samples cover both halves, all slots and both theta signs
        for (int n = 0; n < N_RANDOM; n++) begin
            apply_sample(random_state());
        end

        // Let the last samples leave the pipeline
        target      = applied;
        wait_cycles = 0;
        while (checked < target && wait_cycles < DRAIN_LIMIT) begin
            step_edge(taken);
            wait_cycles++;
        end
        if (checked >= target) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with("pipeline outputs did not all arrive before the drain timeout");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+test
verilog/neuro_pkg.sv
verilog/sample_clock_enable.sv
verilog/cortical_feature_stage.sv
verilog/ca3_phase_memory.sv
verilog/phase_coupling_stage.sv
verilog/neural_loop_top.sv
test/neural_loop_tb.sv

// File: Bender.yml
package:
  name: neural_loop

sources:
  - verilog/neuro_pkg.sv
  - verilog/sample_clock_enable.sv
  - verilog/cortical_feature_stage.sv
  - verilog/ca3_phase_memory.sv
  - verilog/phase_coupling_stage.sv
  - verilog/neural_loop_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/neural_loop_tb.sv
